// ==== tests/udp_echo_testdata.txt ====
# H src_ip src_port dst_port udp_len beat_count
# D data keep last user   (all fields hex)
H c0a80105 c350 04d2 0018 2
D 0011223344556601 ff 0 0
D 8899aabbccddeeff ff 1 0
H c0a80106 c351 162e 0010 1
D 1111111111111112 ff 1 0
H c0a80107 d000 04d2 001c 3
D 0123456789abcd03 ff 0 0
D fedcba9876543210 ff 0 1
D 00000000deadbeef 0f 1 1
H 0a000001 0035 0035 0018 2
D 2222222222222222 ff 0 0
D 3333333333333333 ff 1 0
H c0a80108 1f90 04d2 0010 1
D a5a5a5a55a5a5a04 ff 1 1
H 0a000002 ea60 04d2 0014 2
D 0f0e0d0c0b0a0905 ff 0 0
D 0000000013121110 0f 1 0
H c0a80109 04d3 04d3 0010 1
D 4444444444444444 ff 1 0
H c0a8010a 8000 04d2 000a 1
D 0000000000000a06 03 1 0

// ==== project.f ====
+incdir+logic
logic/udp_hdr_pkg.sv
logic/axis_pkg.sv
logic/udp_frame_filter.sv
logic/udp_reply_header.sv
logic/payload_fifo.sv
logic/first_byte_led.sv
logic/udp_echo_top.sv
tests/udp_echo_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = udp_echo_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/udp_echo_tb.sv ====
`timescale 1ns/1ps

module udp_echo_tb;

    localparam int CLK_PERIOD        = 100;
    localparam int CYCLES_PER_RECORD = 400;

    // Reply constants of this node
    localparam udp_hdr_pkg::ip_addr_t  LOCAL_IP  = 32'hc0a8_0180;
    localparam udp_hdr_pkg::udp_port_t ECHO_PORT = 16'd1234;
    localparam udp_hdr_pkg::udp_port_t ALT_PORT  = 16'd5678;
    localparam udp_hdr_pkg::ip_ttl_t   REPLY_TTL = 8'd64;

    logic                   clk;
    logic                   rst;
    logic                   rx_hdr_valid;
    logic                   rx_hdr_ready;
    udp_hdr_pkg::ip_addr_t  rx_ip_src;
    udp_hdr_pkg::udp_port_t rx_src_port;
    udp_hdr_pkg::udp_port_t rx_dst_port;
    udp_hdr_pkg::udp_len_t  rx_udp_len;
    logic                   rx_pay_valid;
    logic                   rx_pay_ready;
    axis_pkg::beat_data_t   rx_pay_data;
    axis_pkg::beat_keep_t   rx_pay_keep;
    logic                   rx_pay_last;
    logic                   rx_pay_user;
    logic                   tx_hdr_valid;
    logic                   tx_hdr_ready;
    udp_hdr_pkg::ip_addr_t  tx_ip_src;
    udp_hdr_pkg::ip_addr_t  tx_ip_dst;
    udp_hdr_pkg::udp_port_t tx_src_port;
    udp_hdr_pkg::udp_port_t tx_dst_port;
    udp_hdr_pkg::udp_len_t  tx_udp_len;
    udp_hdr_pkg::ip_ttl_t   tx_ttl;
    logic                   tx_pay_valid;
    logic                   tx_pay_ready;
    axis_pkg::beat_data_t   tx_pay_data;
    axis_pkg::beat_keep_t   tx_pay_keep;
    logic                   tx_pay_last;
    logic                   tx_pay_user;
    axis_pkg::led_byte_t    led;
    udp_hdr_pkg::port_hit_t port_hit;

    // Records from the data file, in file order
    udp_hdr_pkg::ip_addr_t  hdr_ip_q[$];
    udp_hdr_pkg::udp_port_t hdr_sport_q[$];
    udp_hdr_pkg::udp_port_t hdr_dport_q[$];
    udp_hdr_pkg::udp_len_t  hdr_len_q[$];
    int                     hdr_beats_q[$];
    axis_pkg::beat_data_t   beat_data_q[$];
    axis_pkg::beat_keep_t   beat_keep_q[$];
    logic                   beat_last_q[$];
    logic                   beat_user_q[$];

    // Indices of records still owed on the tx side
    int                     exp_hdr_idx[$];
    int                     exp_beat_idx[$];

    integer                 seed;
    int                     num_records;
    logic                   file_loaded;
    logic                   hit_due;
    udp_hdr_pkg::port_hit_t hit_exp;
    logic                   led_due;
    axis_pkg::led_byte_t    led_exp;
    logic                   tx_first;
    int                     hi;
    int                     bi;
    int                     k;

    udp_echo_top u_udp_echo_top (.*);

    initial begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic report_mismatch(
        input string       name,
        input logic [63:0] got,
        input logic [63:0] exp
    );
        abort_run($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    task automatic check_hdr(
        input udp_hdr_pkg::ip_addr_t  ip_src,
        input udp_hdr_pkg::ip_addr_t  ip_dst,
        input udp_hdr_pkg::udp_port_t src_port,
        input udp_hdr_pkg::udp_port_t dst_port,
        input udp_hdr_pkg::udp_len_t  udp_len,
        input udp_hdr_pkg::ip_ttl_t   ttl,
        input udp_hdr_pkg::ip_addr_t  exp_ip_dst,
        input udp_hdr_pkg::udp_port_t exp_src_port,
        input udp_hdr_pkg::udp_port_t exp_dst_port,
        input udp_hdr_pkg::udp_len_t  exp_udp_len
    );
        if (ip_src !== LOCAL_IP) begin
            report_mismatch("tx_ip_src", ip_src, LOCAL_IP);
        end else if (ip_dst !== exp_ip_dst) begin
            report_mismatch("tx_ip_dst", ip_dst, exp_ip_dst);
        end else if (src_port !== exp_src_port) begin
            report_mismatch("tx_src_port", src_port, exp_src_port);
        end else if (dst_port !== exp_dst_port) begin
            report_mismatch("tx_dst_port", dst_port, exp_dst_port);
        end else if (udp_len !== exp_udp_len) begin
            report_mismatch("tx_udp_len", udp_len, exp_udp_len);
        end else if (ttl !== REPLY_TTL) begin
            report_mismatch("tx_ttl", ttl, REPLY_TTL);
        end
    endtask

    task automatic check_beat(
        input axis_pkg::beat_data_t data,
        input axis_pkg::beat_keep_t keep,
        input logic                 last,
        input logic                 user,
        input axis_pkg::beat_data_t exp_data,
        input axis_pkg::beat_keep_t exp_keep,
        input logic                 exp_last,
        input logic                 exp_user
    );
        if (data !== exp_data) begin
            report_mismatch("tx_pay_data", data, exp_data);
        end else if (keep !== exp_keep) begin
            report_mismatch("tx_pay_keep", keep, exp_keep);
        end else if (last !== exp_last) begin
            report_mismatch("tx_pay_last", last, exp_last);
        end else if (user !== exp_user) begin
            report_mismatch("tx_pay_user", user, exp_user);
        end
    endtask

    task automatic check_led(input axis_pkg::led_byte_t got, input axis_pkg::led_byte_t exp);
        if (got !== exp) begin
            report_mismatch("led", got, exp);
        end
    endtask

    task automatic check_hit(
        input udp_hdr_pkg::port_hit_t got,
        input udp_hdr_pkg::port_hit_t exp
    );
        if (got !== exp) begin
            report_mismatch("port_hit", got, exp);
        end
    endtask

    function automatic udp_hdr_pkg::port_hit_t expected_hit(input udp_hdr_pkg::udp_port_t port);
        if (port == ECHO_PORT) begin
            return 2'b01;
        end else if (port == ALT_PORT) begin
            return 2'b10;
        end
        return 2'b00;
    endfunction

    // H lines open a datagram, D lines are its beats, # starts a comment
    task automatic load_records();
        int                     fd;
        int                     c;
        int                     n;
        int                     beats_declared;
        logic                   echoed;
        udp_hdr_pkg::ip_addr_t  ip;
        udp_hdr_pkg::udp_port_t sport;
        udp_hdr_pkg::udp_port_t dport;
        udp_hdr_pkg::udp_len_t  len;
        logic [15:0]            beats;
        axis_pkg::beat_data_t   data;
        axis_pkg::beat_keep_t   keep;
        logic                   last;
        logic                   user;
        fd = $fopen("tests/udp_echo_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open the data file tests/udp_echo_testdata.txt");
        end
        beats_declared = 0;
        echoed = 1'b0;
        c = $fgetc(fd);
        while (c != -1) begin
            if (c == "#") begin
                while (c != -1 && c != "\n") begin
                    c = $fgetc(fd);
                end
            end else if (c == "H") begin
                n = $fscanf(fd, "%h %h %h %h %h", ip, sport, dport, len, beats);
                if (n != 5) begin
                    abort_run("Malformed header record in the data file");
                end
                // Only the echo port gets a reply
                echoed = (dport == ECHO_PORT);
                if (echoed) begin
                    exp_hdr_idx.push_back(hdr_ip_q.size());
                end
                hdr_ip_q.push_back(ip);
                hdr_sport_q.push_back(sport);
                hdr_dport_q.push_back(dport);
                hdr_len_q.push_back(len);
                hdr_beats_q.push_back(int'(beats));
                beats_declared += int'(beats);
            end else if (c == "D") begin
                n = $fscanf(fd, "%h %h %h %h", data, keep, last, user);
                if (n != 4) begin
                    abort_run("Malformed data record in the data file");
                end
                if (echoed) begin
                    exp_beat_idx.push_back(beat_data_q.size());
                end
                beat_data_q.push_back(data);
                beat_keep_q.push_back(keep);
                beat_last_q.push_back(last);
                beat_user_q.push_back(user);
            end else if (c != " " && c != "\n" && c != "\t" && c != "\r") begin
                abort_run("Unknown record type in the data file");
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
        if (beats_declared != beat_data_q.size()) begin
            abort_run("Beat counts in the data file do not match its data records");
        end
        num_records = hdr_ip_q.size() + beat_data_q.size();
    endtask

    task automatic take_header();
        int i;
        if (exp_hdr_idx.size() == 0) begin
            abort_run("Reply header sent while none was expected");
        end
        i = exp_hdr_idx.pop_front();
        // Reply swaps both the addresses and the ports
        check_hdr(tx_ip_src, tx_ip_dst, tx_src_port, tx_dst_port, tx_udp_len, tx_ttl,
                  hdr_ip_q[i], hdr_dport_q[i], hdr_sport_q[i], hdr_len_q[i]);
    endtask

    task automatic take_beat();
        int i;
        if (exp_beat_idx.size() == 0) begin
            abort_run("Payload beat sent while none was expected");
        end
        i = exp_beat_idx.pop_front();
        check_beat(tx_pay_data, tx_pay_keep, tx_pay_last, tx_pay_user,
                   beat_data_q[i], beat_keep_q[i], beat_last_q[i], beat_user_q[i]);
        if (tx_first) begin
            led_due = 1'b1;
            led_exp = beat_data_q[i][7:0];
        end
        tx_first = beat_last_q[i];
    endtask

    // Random tx back-pressure
    always @(posedge clk) begin
        #1;
        tx_hdr_ready = ($random(seed) & 1) != 0;
        tx_pay_ready = ($random(seed) & 3) != 0;
    end

    // Outputs are sampled at the edge, before the DUT updates
    always @(posedge clk) begin
        if (!rst) begin
            if (hit_due) begin
                check_hit(port_hit, hit_exp);
            end
            hit_due = rx_hdr_valid && rx_hdr_ready;
            hit_exp = expected_hit(rx_dst_port);
            if (led_due) begin
                check_led(led, led_exp);
            end
            led_due = 1'b0;
            if (tx_hdr_valid && tx_hdr_ready) begin
                take_header();
            end
            if (tx_pay_valid && tx_pay_ready) begin
                take_beat();
            end
        end
    end

    initial begin
        wait (file_loaded);
        #(num_records * CYCLES_PER_RECORD * CLK_PERIOD);
        abort_run("Timeout, the DUT did not finish the datagrams in time");
    end

    initial begin
        seed         = 99;
        rst          = 1'b1;
        rx_hdr_valid = 1'b0;
        rx_ip_src    = '0;
        rx_src_port  = '0;
        rx_dst_port  = '0;
        rx_udp_len   = '0;
        rx_pay_valid = 1'b0;
        rx_pay_data  = '0;
        rx_pay_keep  = '0;
        rx_pay_last  = 1'b0;
        rx_pay_user  = 1'b0;
        tx_hdr_ready = 1'b0;
        tx_pay_ready = 1'b0;
        hit_due      = 1'b0;
        hit_exp      = '0;
        led_due      = 1'b0;
        led_exp      = '0;
        tx_first     = 1'b1;
        num_records  = 0;
        file_loaded  = 1'b0;
        load_records();
        file_loaded = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        bi = 0;
        for (hi = 0; hi < hdr_ip_q.size(); hi++) begin
            rx_hdr_valid = 1'b1;
            rx_ip_src    = hdr_ip_q[hi];
            rx_src_port  = hdr_sport_q[hi];
            rx_dst_port  = hdr_dport_q[hi];
            rx_udp_len   = hdr_len_q[hi];
            do begin
                @(posedge clk);
            end while (!rx_hdr_ready);
            #1;
            rx_hdr_valid = 1'b0;
            for (k = 0; k < hdr_beats_q[hi]; k++) begin
                rx_pay_valid = 1'b1;
                rx_pay_data  = beat_data_q[bi];
                rx_pay_keep  = beat_keep_q[bi];
                rx_pay_last  = beat_last_q[bi];
                rx_pay_user  = beat_user_q[bi];
                bi++;
                do begin
                    @(posedge clk);
                end while (!rx_pay_ready);
                #1;
            end
            rx_pay_valid = 1'b0;
        end
        // Drain everything still held in the DUT
        while (exp_hdr_idx.size() != 0 || exp_beat_idx.size() != 0) begin
            @(negedge clk);
        end
        repeat (20) @(posedge clk);
        @(negedge clk);
        if (exp_hdr_idx.size() != 0 || exp_beat_idx.size() != 0
            || tx_hdr_valid || tx_pay_valid) begin
            abort_run("DUT still presents output after the last datagram");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

// ==== logic/udp_echo_top.sv ====
`timescale 1ns/1ps

module udp_echo_top (
    input  logic                   clk,
    input  logic                   rst,
    // Received header
    input  logic                   rx_hdr_valid,
    output logic                   rx_hdr_ready,
    input  udp_hdr_pkg::ip_addr_t  rx_ip_src,
    input  udp_hdr_pkg::udp_port_t rx_src_port,
    input  udp_hdr_pkg::udp_port_t rx_dst_port,
    input  udp_hdr_pkg::udp_len_t  rx_udp_len,
    // Received payload
    input  logic                   rx_pay_valid,
    output logic                   rx_pay_ready,
    input  axis_pkg::beat_data_t   rx_pay_data,
    input  axis_pkg::beat_keep_t   rx_pay_keep,
    input  logic                   rx_pay_last,
    input  logic                   rx_pay_user,
    // Reply header
    output logic                   tx_hdr_valid,
    input  logic                   tx_hdr_ready,
    output udp_hdr_pkg::ip_addr_t  tx_ip_src,
    output udp_hdr_pkg::ip_addr_t  tx_ip_dst,
    output udp_hdr_pkg::udp_port_t tx_src_port,
    output udp_hdr_pkg::udp_port_t tx_dst_port,
    output udp_hdr_pkg::udp_len_t  tx_udp_len,
    output udp_hdr_pkg::ip_ttl_t   tx_ttl,
    // Reply payload
    output logic                   tx_pay_valid,
    input  logic                   tx_pay_ready,
    output axis_pkg::beat_data_t   tx_pay_data,
    output axis_pkg::beat_keep_t   tx_pay_keep,
    output logic                   tx_pay_last,
    output logic                   tx_pay_user,
    // Status
    output axis_pkg::led_byte_t    led,
    output udp_hdr_pkg::port_hit_t port_hit
);

    // Filter to reply header stage
    logic                   hdr_valid;
    logic                   hdr_ready;
    udp_hdr_pkg::ip_addr_t  src_ip;
    udp_hdr_pkg::udp_port_t src_port;
    udp_hdr_pkg::udp_port_t dst_port;
    udp_hdr_pkg::udp_len_t  udp_len;

    // Filter to payload FIFO
    logic                   fifo_in_valid;
    logic                   fifo_in_ready;
    axis_pkg::beat_data_t   fifo_in_data;
    axis_pkg::beat_keep_t   fifo_in_keep;
    logic                   fifo_in_last;
    logic                   fifo_in_user;

    udp_frame_filter u_udp_frame_filter (
        .clk           (clk),
        .rst           (rst),
        .rx_hdr_valid  (rx_hdr_valid),
        .rx_hdr_ready  (rx_hdr_ready),
        .rx_ip_src     (rx_ip_src),
        .rx_src_port   (rx_src_port),
        .rx_dst_port   (rx_dst_port),
        .rx_udp_len    (rx_udp_len),
        .rx_pay_valid  (rx_pay_valid),
        .rx_pay_ready  (rx_pay_ready),
        .rx_pay_data   (rx_pay_data),
        .rx_pay_keep   (rx_pay_keep),
        .rx_pay_last   (rx_pay_last),
        .rx_pay_user   (rx_pay_user),
        .hdr_valid     (hdr_valid),
        .hdr_ready     (hdr_ready),
        .src_ip        (src_ip),
        .src_port      (src_port),
        .dst_port      (dst_port),
        .udp_len       (udp_len),
        .fifo_in_valid (fifo_in_valid),
        .fifo_in_ready (fifo_in_ready),
        .fifo_in_data  (fifo_in_data),
        .fifo_in_keep  (fifo_in_keep),
        .fifo_in_last  (fifo_in_last),
        .fifo_in_user  (fifo_in_user),
        .port_hit      (port_hit)
    );

    udp_reply_header u_udp_reply_header (
        .clk          (clk),
        .rst          (rst),
        .hdr_valid    (hdr_valid),
        .hdr_ready    (hdr_ready),
        .src_ip       (src_ip),
        .src_port     (src_port),
        .dst_port     (dst_port),
        .udp_len      (udp_len),
        .tx_hdr_valid (tx_hdr_valid),
        .tx_hdr_ready (tx_hdr_ready),
        .tx_ip_src    (tx_ip_src),
        .tx_ip_dst    (tx_ip_dst),
        .tx_src_port  (tx_src_port),
        .tx_dst_port  (tx_dst_port),
        .tx_udp_len   (tx_udp_len),
        .tx_ttl       (tx_ttl)
    );

    payload_fifo u_payload_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (fifo_in_valid),
        .in_ready  (fifo_in_ready),
        .in_data   (fifo_in_data),
        .in_keep   (fifo_in_keep),
        .in_last   (fifo_in_last),
        .in_user   (fifo_in_user),
        .out_valid (tx_pay_valid),
        .out_ready (tx_pay_ready),
        .out_data  (tx_pay_data),
        .out_keep  (tx_pay_keep),
        .out_last  (tx_pay_last),
        .out_user  (tx_pay_user)
    );

    // Watches the outgoing payload only
    first_byte_led u_first_byte_led (
        .clk       (clk),
        .rst       (rst),
        .pay_valid (tx_pay_valid),
        .pay_ready (tx_pay_ready),
        .pay_data  (tx_pay_data),
        .pay_last  (tx_pay_last),
        .led       (led)
    );

endmodule

// ==== logic/first_byte_led.sv ====
`timescale 1ns/1ps

module first_byte_led (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pay_valid,
    input  logic                 pay_ready,
    input  axis_pkg::beat_data_t pay_data,
    input  logic                 pay_last,
    output axis_pkg::led_byte_t  led
);

    // Next beat opens a datagram
    logic at_start;
    logic pay_xfer;

    assign pay_xfer = pay_valid && pay_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            at_start <= 1'b1;
            led      <= '0;
        end else if (pay_xfer) begin
            at_start <= pay_last;
            if (at_start) begin
                // Byte 0 sits in the low lane
                led <= pay_data[7:0];
            end
        end
    end

endmodule

// ==== logic/payload_fifo.sv ====
`timescale 1ns/1ps
`include "echo_cfg.svh"

module payload_fifo #(
    parameter int DEPTH = `ECHO_FIFO_DEPTH
) (
    input  logic                 clk,
    input  logic                 rst,
    // Write side
    input  logic                 in_valid,
    output logic                 in_ready,
    input  axis_pkg::beat_data_t in_data,
    input  axis_pkg::beat_keep_t in_keep,
    input  logic                 in_last,
    input  logic                 in_user,
    // Read side
    output logic                 out_valid,
    input  logic                 out_ready,
    output axis_pkg::beat_data_t out_data,
    output axis_pkg::beat_keep_t out_keep,
    output logic                 out_last,
    output logic                 out_user
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [AW-1:0] LAST_PTR = AW'(DEPTH - 1);
    localparam logic [AW:0] FULL_COUNT = (AW + 1)'(DEPTH);

    axis_pkg::beat_data_t mem_data [DEPTH];
    axis_pkg::beat_keep_t mem_keep [DEPTH];
    // last in bit 1, user in bit 0
    logic [1:0]           mem_ctrl [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          wr_en;
    logic          rd_en;

    assign in_ready  = (count != FULL_COUNT);
    assign out_valid = (count != '0);
    assign wr_en     = in_valid && in_ready;
    assign rd_en     = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_data[wr_ptr] <= in_data;
            mem_keep[wr_ptr] <= in_keep;
            mem_ctrl[wr_ptr] <= {in_last, in_user};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head entry is visible as soon as count goes nonzero
    assign out_data = mem_data[rd_ptr];
    assign out_keep = mem_keep[rd_ptr];
    assign out_last = mem_ctrl[rd_ptr][1];
    assign out_user = mem_ctrl[rd_ptr][0];

    a_no_write_full: assert property (
        @(posedge clk) disable iff (rst) (count == FULL_COUNT) |-> !wr_en
    );

    a_count_bound: assert property (
        @(posedge clk) disable iff (rst) count <= FULL_COUNT
    );

endmodule

// ==== logic/udp_reply_header.sv ====
`timescale 1ns/1ps
`include "echo_cfg.svh"

module udp_reply_header (
    input  logic                   clk,
    input  logic                   rst,
    // Header of the received datagram
    input  logic                   hdr_valid,
    output logic                   hdr_ready,
    input  udp_hdr_pkg::ip_addr_t  src_ip,
    input  udp_hdr_pkg::udp_port_t src_port,
    input  udp_hdr_pkg::udp_port_t dst_port,
    input  udp_hdr_pkg::udp_len_t  udp_len,
    // Reply header
    output logic                   tx_hdr_valid,
    input  logic                   tx_hdr_ready,
    output udp_hdr_pkg::ip_addr_t  tx_ip_src,
    output udp_hdr_pkg::ip_addr_t  tx_ip_dst,
    output udp_hdr_pkg::udp_port_t tx_src_port,
    output udp_hdr_pkg::udp_port_t tx_dst_port,
    output udp_hdr_pkg::udp_len_t  tx_udp_len,
    output udp_hdr_pkg::ip_ttl_t   tx_ttl
);

    logic load;

    // Free slot, or the held header leaves this cycle
    assign hdr_ready = !tx_hdr_valid || tx_hdr_ready;
    assign load      = hdr_valid && hdr_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_hdr_valid <= 1'b0;
        end else if (load) begin
            tx_hdr_valid <= 1'b1;
        end else if (tx_hdr_ready) begin
            tx_hdr_valid <= 1'b0;
        end
    end

    // Reply goes back where it came from, ports swapped
    always_ff @(posedge clk) begin
        if (load) begin
            tx_ip_dst   <= src_ip;
            tx_src_port <= dst_port;
            tx_dst_port <= src_port;
            tx_udp_len  <= udp_len;
        end
    end

    assign tx_ip_src = `ECHO_LOCAL_IP;
    assign tx_ttl    = `ECHO_TTL;

    a_hold_stable: assert property (
        @(posedge clk) disable iff (rst)
        (tx_hdr_valid && !tx_hdr_ready) |=>
            tx_hdr_valid && $stable(tx_ip_dst) && $stable(tx_src_port)
            && $stable(tx_dst_port) && $stable(tx_udp_len)
    );

endmodule

// ==== logic/udp_frame_filter.sv ====
`timescale 1ns/1ps
`include "echo_cfg.svh"

module udp_frame_filter (
    input  logic                   clk,
    input  logic                   rst,
    // Received header
    input  logic                   rx_hdr_valid,
    output logic                   rx_hdr_ready,
    input  udp_hdr_pkg::ip_addr_t  rx_ip_src,
    input  udp_hdr_pkg::udp_port_t rx_src_port,
    input  udp_hdr_pkg::udp_port_t rx_dst_port,
    input  udp_hdr_pkg::udp_len_t  rx_udp_len,
    // Received payload
    input  logic                   rx_pay_valid,
    output logic                   rx_pay_ready,
    input  axis_pkg::beat_data_t   rx_pay_data,
    input  axis_pkg::beat_keep_t   rx_pay_keep,
    input  logic                   rx_pay_last,
    input  logic                   rx_pay_user,
    // Header of an echoed datagram
    output logic                   hdr_valid,
    input  logic                   hdr_ready,
    output udp_hdr_pkg::ip_addr_t  src_ip,
    output udp_hdr_pkg::udp_port_t src_port,
    output udp_hdr_pkg::udp_port_t dst_port,
    output udp_hdr_pkg::udp_len_t  udp_len,
    // Payload of an echoed datagram
    output logic                   fifo_in_valid,
    input  logic                   fifo_in_ready,
    output axis_pkg::beat_data_t   fifo_in_data,
    output axis_pkg::beat_keep_t   fifo_in_keep,
    output logic                   fifo_in_last,
    output logic                   fifo_in_user,
    // Classification of the last header
    output udp_hdr_pkg::port_hit_t port_hit
);

    logic in_payload;
    logic keep_dgram;
    logic is_echo;
    logic is_alt;
    logic hdr_xfer;
    logic pay_xfer;

    assign is_echo = (rx_dst_port == `ECHO_PORT);
    assign is_alt  = (rx_dst_port == `ECHO_ALT_PORT);

    // Dropped headers never wait on the reply stage
    assign rx_hdr_ready = !in_payload && (!is_echo || hdr_ready);
    assign hdr_valid    = !in_payload && rx_hdr_valid && is_echo;
    assign hdr_xfer     = rx_hdr_valid && rx_hdr_ready;

    assign src_ip   = rx_ip_src;
    assign src_port = rx_src_port;
    assign dst_port = rx_dst_port;
    assign udp_len  = rx_udp_len;

    // Kept beats see the FIFO, dropped beats are swallowed
    assign fifo_in_valid = in_payload && keep_dgram && rx_pay_valid;
    assign rx_pay_ready  = in_payload && (!keep_dgram || fifo_in_ready);
    assign pay_xfer      = rx_pay_valid && rx_pay_ready;

    assign fifo_in_data = rx_pay_data;
    assign fifo_in_keep = rx_pay_keep;
    assign fifo_in_last = rx_pay_last;
    assign fifo_in_user = rx_pay_user;

    // Idle / payload phase, one datagram at a time
    always_ff @(posedge clk) begin
        if (rst) begin
            in_payload <= 1'b0;
            keep_dgram <= 1'b0;
        end else if (!in_payload) begin
            if (hdr_xfer) begin
                in_payload <= 1'b1;
                keep_dgram <= is_echo;
            end
        end else if (pay_xfer && rx_pay_last) begin
            in_payload <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            port_hit <= '0;
        end else if (hdr_xfer) begin
            port_hit <= {is_alt, is_echo};
        end
    end

    a_no_idle_payload: assert property (
        @(posedge clk) disable iff (rst)
        (rx_pay_valid && rx_pay_ready) |-> in_payload
    );

endmodule

// ==== logic/axis_pkg.sv ====
`include "echo_cfg.svh"

package axis_pkg;

    // Payload data of one beat, byte 0 in the low bits
    typedef logic [`ECHO_DATA_WIDTH-1:0] beat_data_t;

    // Byte enables of one beat
    typedef logic [`ECHO_KEEP_WIDTH-1:0] beat_keep_t;

    // Single payload byte as shown on the LEDs
    typedef logic [7:0] led_byte_t;

endpackage

// ==== logic/udp_hdr_pkg.sv ====
package udp_hdr_pkg;

    // IPv4 address, first octet in the top byte
    typedef logic [31:0] ip_addr_t;

    // UDP port number
    typedef logic [15:0] udp_port_t;

    // UDP length field, header plus payload in bytes
    typedef logic [15:0] udp_len_t;

    // IP time-to-live
    typedef logic [7:0] ip_ttl_t;

    // One-hot match of a destination port
    // Bit 0 is the echo port, bit 1 the alternate port
    typedef logic [1:0] port_hit_t;

endpackage

// ==== logic/echo_cfg.svh ====
`ifndef ECHO_CFG_SVH
`define ECHO_CFG_SVH

// Payload stream geometry
`define ECHO_DATA_WIDTH 64
`define ECHO_KEEP_WIDTH 8

// Payload buffer entries, one beat each
`define ECHO_FIFO_DEPTH 512

// Address of this node, 192.168.1.128
`define ECHO_LOCAL_IP {8'd192, 8'd168, 8'd1, 8'd128}

// Datagrams to this port are echoed back
`define ECHO_PORT 16'd1234

// Second known port, classified but never echoed
`define ECHO_ALT_PORT 16'd5678

// Time-to-live placed in every reply
`define ECHO_TTL 8'd64

`endif
